// ==== source/debug_pkg.sv ====
// ------------------------------
// Single hart, one data register, no program buffer
// Only register-access abstract commands are decoded
// ------------------------------
package debug_pkg;

	localparam int DMI_ABITS = 7;
	// Address, 32-bit data and 2-bit op
	localparam int DMI_DR_W = DMI_ABITS + 34;

	// Requests use nop/read/write, responses reuse the codes as status
	typedef enum logic [1:0] {
		DMI_OP_NOP   = 2'd0,
		DMI_OP_READ  = 2'd1,
		DMI_OP_WRITE = 2'd2,
		DMI_OP_BUSY  = 2'd3
	} dmi_op_t;

	localparam dmi_op_t DMI_ST_SUCCESS = DMI_OP_NOP;
	localparam dmi_op_t DMI_ST_FAILED = DMI_OP_WRITE;

	localparam logic [DMI_ABITS-1:0] DM_DATA0 = 7'h04;
	localparam logic [DMI_ABITS-1:0] DM_DMCONTROL = 7'h10;
	localparam logic [DMI_ABITS-1:0] DM_DMSTATUS = 7'h11;
	localparam logic [DMI_ABITS-1:0] DM_ABSTRACTCS = 7'h16;
	localparam logic [DMI_ABITS-1:0] DM_COMMAND = 7'h17;

	typedef enum logic [2:0] {
		CMDERR_NONE       = 3'd0,
		CMDERR_BUSY       = 3'd1,
		CMDERR_NOTSUP     = 3'd2,
		CMDERR_EXCEPTION  = 3'd3,
		CMDERR_HALTRESUME = 3'd4
	} cmderr_t;

	localparam int NUM_GPR = 16;
	localparam logic [15:0] REGNO_GPR_BASE = 16'h1000;
	localparam logic [3:0] DMSTATUS_VERSION = 4'd2;
	localparam logic [3:0] ABS_DATACOUNT = 4'd1;

	typedef struct packed {
		logic        haltreq;
		logic        resumereq;
		logic [27:0] rsvd;
		logic        ndmreset;
		logic        dmactive;
	} dmcontrol_t;

	typedef struct packed {
		logic [7:0]  cmdtype;
		logic [5:0]  rsvd;
		logic        transfer;
		logic        write;
		logic [15:0] regno;
	} command_t;

	// One DMI write word, seen as dmcontrol or as an abstract command
	typedef union packed {
		dmcontrol_t ctrl;
		command_t   cmd;
	} dm_word_u;

endpackage

// ==== source/jtag_pkg.sv ====
// ------------------------------
// Standard 16-state TAP, 5-bit IR
// ------------------------------
package jtag_pkg;

	typedef enum logic [3:0] {
		TAP_RESET      = 4'h0,
		TAP_IDLE       = 4'h1,
		TAP_SELECT_DR  = 4'h2,
		TAP_CAPTURE_DR = 4'h3,
		TAP_SHIFT_DR   = 4'h4,
		TAP_EXIT1_DR   = 4'h5,
		TAP_PAUSE_DR   = 4'h6,
		TAP_EXIT2_DR   = 4'h7,
		TAP_UPDATE_DR  = 4'h8,
		TAP_SELECT_IR  = 4'h9,
		TAP_CAPTURE_IR = 4'ha,
		TAP_SHIFT_IR   = 4'hb,
		TAP_EXIT1_IR   = 4'hc,
		TAP_PAUSE_IR   = 4'hd,
		TAP_EXIT2_IR   = 4'he,
		TAP_UPDATE_IR  = 4'hf
	} tap_state_t;

	localparam logic [4:0] IR_IDCODE = 5'h01;
	localparam logic [4:0] IR_DTMCS = 5'h10;
	localparam logic [4:0] IR_DMI = 5'h11;
	localparam logic [4:0] IR_BYPASS = 5'h1f;

	localparam logic [31:0] IDCODE_VALUE = 32'hdeadbeef;
	localparam logic [3:0] DTMCS_VERSION = 4'd1;
	localparam logic [2:0] DTMCS_IDLE = 3'd1;

endpackage

// ==== source/dmi_if.sv ====
// ------------------------------
// One outstanding request, response one cycle after accept
// ------------------------------
interface dmi_if import debug_pkg::*; ();

	logic                 req_valid;
	logic                 req_ready;
	logic [DMI_ABITS-1:0] addr;
	logic [31:0]          wdata;
	dmi_op_t              op;
	logic                 rsp_valid;
	logic [31:0]          rdata;
	logic                 rsp_err;

	modport master (
		output req_valid, addr, wdata, op,
		input  req_ready, rsp_valid, rdata, rsp_err
	);

	modport slave (
		input  req_valid, addr, wdata, op,
		output req_ready, rsp_valid, rdata, rsp_err
	);

endinterface

// ==== source/hart_dbg_if.sv ====
// ------------------------------
// Run control as levels, register access as valid/ready
// ------------------------------
interface hart_dbg_if;

	// Run control
	logic        halt_req;
	logic        resume_req;
	logic        halted;
	logic        running;

	// Register access
	logic        acc_valid;
	logic        acc_ready;
	logic [15:0] regno;
	logic        write;
	logic [31:0] wdata;
	logic        acc_done;
	logic [31:0] rdata;
	logic        acc_err;

	modport dm (
		output halt_req, resume_req, acc_valid, regno, write, wdata,
		input  halted, running, acc_ready, acc_done, rdata, acc_err
	);

	modport hart (
		input  halt_req, resume_req, acc_valid, regno, write, wdata,
		output halted, running, acc_ready, acc_done, rdata, acc_err
	);

endinterface

// ==== source/reset_sync.sv ====
// ------------------------------
// Output follows input at once, releases two clocks late
// ------------------------------
module reset_sync (
	input  logic clk,
	input  logic i_rst_async,
	output logic o_rst
);

	logic [1:0] hold;

	always_ff @(posedge clk) begin
		if (i_rst_async) begin
			hold <= 2'b11;
		end else begin
			hold <= {hold[0], 1'b0};
		end
	end

	assign o_rst = i_rst_async | hold[1];

endmodule

// ==== source/jtag_tap.sv ====
// ------------------------------
// TCK is oversampled on clk, each TCK level needs 4+ clocks
// i_trst is active high
// ------------------------------
module jtag_tap
	import debug_pkg::*;
	import jtag_pkg::*;
(
	input  logic  clk,
	input  logic  i_rst,
	input  logic  i_tck,
	input  logic  i_tms,
	input  logic  i_tdi,
	input  logic  i_trst,
	output logic  o_tdo,
	dmi_if.master dmi
);

	logic [1:0]          tck_sync, tms_sync, tdi_sync, trst_sync;
	logic                tck_d, tck_rise, tck_fall, tms, tdi;
	tap_state_t          state, state_nxt;
	logic [4:0]          ir, ir_sh;
	logic [DMI_DR_W-1:0] dr;
	logic [31:0]         dtmcs_word, rdata_q;
	dmi_op_t             dmi_stat;
	logic                dmi_pending;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			tck_sync <= '0;
			tms_sync <= '0;
			tdi_sync <= '0;
			trst_sync <= '0;
			tck_d <= 1'b0;
		end else begin
			tck_sync <= {tck_sync[0], i_tck};
			tms_sync <= {tms_sync[0], i_tms};
			tdi_sync <= {tdi_sync[0], i_tdi};
			trst_sync <= {trst_sync[0], i_trst};
			tck_d <= tck_sync[1];
		end
	end

	assign tck_rise = tck_sync[1] & ~tck_d;
	assign tck_fall = ~tck_sync[1] & tck_d;
	assign tms = tms_sync[1];
	assign tdi = tdi_sync[1];

	always_comb begin
		case (state)
			TAP_RESET:      state_nxt = tms ? TAP_RESET : TAP_IDLE;
			TAP_IDLE:       state_nxt = tms ? TAP_SELECT_DR : TAP_IDLE;
			TAP_SELECT_DR:  state_nxt = tms ? TAP_SELECT_IR : TAP_CAPTURE_DR;
			TAP_CAPTURE_DR: state_nxt = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_SHIFT_DR:   state_nxt = tms ? TAP_EXIT1_DR : TAP_SHIFT_DR;
			TAP_EXIT1_DR:   state_nxt = tms ? TAP_UPDATE_DR : TAP_PAUSE_DR;
			TAP_PAUSE_DR:   state_nxt = tms ? TAP_EXIT2_DR : TAP_PAUSE_DR;
			TAP_EXIT2_DR:   state_nxt = tms ? TAP_UPDATE_DR : TAP_SHIFT_DR;
			TAP_UPDATE_DR:  state_nxt = tms ? TAP_SELECT_DR : TAP_IDLE;
			TAP_SELECT_IR:  state_nxt = tms ? TAP_RESET : TAP_CAPTURE_IR;
			TAP_CAPTURE_IR: state_nxt = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_SHIFT_IR:   state_nxt = tms ? TAP_EXIT1_IR : TAP_SHIFT_IR;
			TAP_EXIT1_IR:   state_nxt = tms ? TAP_UPDATE_IR : TAP_PAUSE_IR;
			TAP_PAUSE_IR:   state_nxt = tms ? TAP_EXIT2_IR : TAP_PAUSE_IR;
			TAP_EXIT2_IR:   state_nxt = tms ? TAP_UPDATE_IR : TAP_SHIFT_IR;
			default:        state_nxt = tms ? TAP_SELECT_DR : TAP_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst || trst_sync[1]) begin
			state <= TAP_RESET;
			ir <= IR_IDCODE;
		end else if (tck_rise) begin
			state <= state_nxt;
			if (state == TAP_RESET)
				ir <= IR_IDCODE;
			else if (state == TAP_UPDATE_IR)
				ir <= ir_sh;
		end
	end

	assign dtmcs_word = {14'b0, 3'b0, DTMCS_IDLE, dmi_stat, 6'(DMI_ABITS), DTMCS_VERSION};

	// Shift registers, IR and DR share the TCK edge
	always_ff @(posedge clk) begin
		if (tck_rise) begin
			if (state == TAP_CAPTURE_IR)
				ir_sh <= 5'b00001;
			else if (state == TAP_SHIFT_IR)
				ir_sh <= {tdi, ir_sh[4:1]};
			if (state == TAP_CAPTURE_DR) begin
				case (ir)
					IR_IDCODE: dr <= DMI_DR_W'(IDCODE_VALUE);
					IR_DTMCS:  dr <= DMI_DR_W'(dtmcs_word);
					IR_DMI:    dr <= {dmi.addr, rdata_q, dmi_pending ? DMI_OP_BUSY : dmi_stat};
					default:   dr <= '0;
				endcase
			end else if (state == TAP_SHIFT_DR) begin
				case (ir)
					IR_DMI:              dr <= {tdi, dr[DMI_DR_W-1:1]};
					IR_IDCODE, IR_DTMCS: dr <= {{(DMI_DR_W-32){1'b0}}, tdi, dr[31:1]};
					default:             dr <= {{(DMI_DR_W-1){1'b0}}, tdi};
				endcase
			end
		end
		if (tck_rise && state == TAP_UPDATE_DR && ir == IR_DMI) begin
			dmi.addr <= dr[DMI_DR_W-1:34];
			dmi.wdata <= dr[33:2];
			dmi.op <= dmi_op_t'(dr[1:0]);
		end
		if (dmi.rsp_valid)
			rdata_q <= dmi.rdata;
	end

	// DMI master with sticky busy and failed status
	always_ff @(posedge clk) begin
		if (i_rst) begin
			dmi.req_valid <= 1'b0;
			dmi_pending <= 1'b0;
			dmi_stat <= DMI_ST_SUCCESS;
		end else begin
			if (dmi.req_valid && dmi.req_ready)
				dmi.req_valid <= 1'b0;
			if (dmi.rsp_valid) begin
				dmi_pending <= 1'b0;
				if (dmi.rsp_err && dmi_stat == DMI_ST_SUCCESS)
					dmi_stat <= DMI_ST_FAILED;
			end
			if (tck_rise && state == TAP_CAPTURE_DR && ir == IR_DMI && dmi_pending)
				dmi_stat <= DMI_OP_BUSY;
			if (tck_rise && state == TAP_UPDATE_DR) begin
				if (ir == IR_DTMCS && dr[16]) begin
					dmi_stat <= DMI_ST_SUCCESS;
				end else if (ir == IR_DMI) begin
					if (dmi_pending)
						dmi_stat <= DMI_OP_BUSY;
					else if (dmi_stat == DMI_ST_SUCCESS && dr[1:0] != DMI_OP_NOP) begin
						dmi.req_valid <= 1'b1;
						dmi_pending <= 1'b1;
					end
				end
			end
		end
	end

	// TDO launched on the falling TCK edge
	always_ff @(posedge clk) begin
		if (i_rst)
			o_tdo <= 1'b0;
		else if (tck_fall)
			o_tdo <= (state == TAP_SHIFT_IR) ? ir_sh[0] : (state == TAP_SHIFT_DR) ? dr[0] : 1'b0;
	end

endmodule

// ==== source/debug_module.sv ====
// ------------------------------
// One hart, data0 only, register-access commands only
// ------------------------------
module debug_module
	import debug_pkg::*;
(
	input  logic      clk,
	input  logic      i_rst,
	dmi_if.slave      dmi,
	hart_dbg_if.dm    hart,
	output logic      o_ndmreset
);

	dm_word_u    wr_word;
	logic        accept, dmi_wr, cmd_start;
	logic        dmactive, resumeack, abs_busy;
	cmderr_t     cmderr;
	logic [31:0] data0;
	logic [31:0] dmcontrol, dmstatus, abstractcs, rd_word;
	logic        rd_err;

	assign wr_word = dmi.wdata;
	assign accept = dmi.req_valid & dmi.req_ready;
	assign dmi_wr = accept && dmi.op == DMI_OP_WRITE;

	// Command goes to the hart only when every check passes
	assign cmd_start = dmi_wr && dmi.addr == DM_COMMAND && !abs_busy &&
		cmderr == CMDERR_NONE && wr_word.cmd.cmdtype == 8'd0 &&
		hart.halted && wr_word.cmd.transfer;

	assign dmcontrol = {hart.halt_req, 1'b0, 28'b0, o_ndmreset, dmactive};
	assign dmstatus = {14'b0, resumeack, resumeack, 4'b0, hart.running, hart.running,
		hart.halted, hart.halted, 1'b1, 3'b0, DMSTATUS_VERSION};
	assign abstractcs = {3'b0, 5'd0, 11'b0, abs_busy, 1'b0, cmderr, 4'b0, ABS_DATACOUNT};

	always_comb begin
		rd_err = 1'b0;
		case (dmi.addr)
			DM_DATA0:      rd_word = data0;
			DM_DMCONTROL:  rd_word = dmcontrol;
			DM_DMSTATUS:   rd_word = dmstatus;
			DM_ABSTRACTCS: rd_word = abstractcs;
			DM_COMMAND:    rd_word = '0;
			default: begin
				rd_word = '0;
				rd_err = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (i_rst) begin
			dmi.req_ready <= 1'b0;
			dmi.rsp_valid <= 1'b0;
			dmi.rsp_err <= 1'b0;
			dmactive <= 1'b0;
			o_ndmreset <= 1'b0;
			hart.halt_req <= 1'b0;
			hart.resume_req <= 1'b0;
			hart.acc_valid <= 1'b0;
			resumeack <= 1'b0;
			abs_busy <= 1'b0;
			cmderr <= CMDERR_NONE;
		end else begin
			dmi.req_ready <= 1'b1;
			dmi.rsp_valid <= accept;
			if (accept)
				dmi.rsp_err <= rd_err;
			// Resume completes once the hart reports running
			if (hart.resume_req && hart.running) begin
				hart.resume_req <= 1'b0;
				resumeack <= 1'b1;
			end
			if (hart.acc_valid && hart.acc_ready)
				hart.acc_valid <= 1'b0;
			if (hart.acc_done) begin
				abs_busy <= 1'b0;
				if (hart.acc_err && cmderr == CMDERR_NONE)
					cmderr <= CMDERR_EXCEPTION;
			end
			if (dmi_wr) begin
				case (dmi.addr)
					DM_DMCONTROL: begin
						dmactive <= wr_word.ctrl.dmactive;
						if (!wr_word.ctrl.dmactive) begin
							hart.halt_req <= 1'b0;
							hart.resume_req <= 1'b0;
							o_ndmreset <= 1'b0;
						end else begin
							hart.halt_req <= wr_word.ctrl.haltreq;
							o_ndmreset <= wr_word.ctrl.ndmreset;
							if (wr_word.ctrl.resumereq && !wr_word.ctrl.haltreq) begin
								hart.resume_req <= 1'b1;
								resumeack <= 1'b0;
							end
						end
					end
					DM_DATA0: begin
						if (abs_busy && cmderr == CMDERR_NONE)
							cmderr <= CMDERR_BUSY;
					end
					DM_ABSTRACTCS: cmderr <= cmderr_t'(cmderr & ~dmi.wdata[10:8]);
					DM_COMMAND: begin
						if (abs_busy) begin
							if (cmderr == CMDERR_NONE)
								cmderr <= CMDERR_BUSY;
						end else if (cmderr == CMDERR_NONE) begin
							if (wr_word.cmd.cmdtype != 8'd0)
								cmderr <= CMDERR_NOTSUP;
							else if (!hart.halted)
								cmderr <= CMDERR_HALTRESUME;
						end
					end
					default: ;
				endcase
			end
			if (cmd_start) begin
				abs_busy <= 1'b1;
				hart.acc_valid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			dmi.rdata <= rd_word;
		if (dmi_wr && dmi.addr == DM_DATA0 && !abs_busy)
			data0 <= dmi.wdata;
		// Register reads land in data0
		if (hart.acc_done && !hart.acc_err && !hart.write)
			data0 <= hart.rdata;
		if (cmd_start) begin
			hart.regno <= wr_word.cmd.regno;
			hart.write <= wr_word.cmd.write;
			hart.wdata <= data0;
		end
	end

endmodule

// ==== source/hart_regs.sv ====
// ------------------------------
// Stand-in hart, no instruction execution
// ------------------------------
module hart_regs
	import debug_pkg::*;
(
	input  logic     clk,
	input  logic     i_rst,
	hart_dbg_if.hart dbg
);

	logic [31:0]                gpr [NUM_GPR];
	logic                       halted_q, stall_q, accept, in_range;
	logic [$clog2(NUM_GPR)-1:0] idx;

	assign accept = dbg.acc_valid & dbg.acc_ready;
	assign in_range = dbg.regno >= REGNO_GPR_BASE && dbg.regno < REGNO_GPR_BASE + NUM_GPR;
	assign idx = dbg.regno[$clog2(NUM_GPR)-1:0];

	// One stall cycle after each accept
	assign dbg.acc_ready = ~stall_q;
	assign dbg.halted = halted_q;
	assign dbg.running = ~halted_q;

	always_ff @(posedge clk) begin
		if (i_rst) begin
			halted_q <= 1'b0;
			stall_q <= 1'b0;
			dbg.acc_done <= 1'b0;
			dbg.acc_err <= 1'b0;
			for (int i = 0; i < NUM_GPR; i++)
				gpr[i] <= '0;
		end else begin
			if (dbg.halt_req && !halted_q)
				halted_q <= 1'b1;
			else if (dbg.resume_req && !dbg.halt_req && halted_q)
				halted_q <= 1'b0;
			stall_q <= accept;
			dbg.acc_done <= accept;
			if (accept) begin
				dbg.acc_err <= ~in_range;
				// x0 stays zero
				if (in_range && dbg.write && idx != '0)
					gpr[idx] <= dbg.wdata;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			dbg.rdata <= (in_range && idx != '0) ? gpr[idx] : '0;
	end

endmodule

// ==== source/debug_top.sv ====
// ------------------------------
// i_trst is active high, hart reset also covers ndmreset
// ------------------------------
module debug_top (
	input  logic clk,
	input  logic i_rst,
	input  logic i_tck,
	input  logic i_tms,
	input  logic i_tdi,
	input  logic i_trst,
	output logic o_tdo,
	output logic o_hart_halted,
	output logic o_hart_running
);

	dmi_if      dmi ();
	hart_dbg_if hart_dbg ();

	logic rst_dmi, rst_hart, ndmreset;

	reset_sync u_dmi_rst (
		.clk         (clk),
		.i_rst_async (i_rst),
		.o_rst       (rst_dmi)
	);

	// Hart held in reset while the DM asserts ndmreset
	reset_sync u_hart_rst (
		.clk         (clk),
		.i_rst_async (i_rst | ndmreset),
		.o_rst       (rst_hart)
	);

	jtag_tap u_tap (
		.clk    (clk),
		.i_rst  (rst_dmi),
		.i_tck  (i_tck),
		.i_tms  (i_tms),
		.i_tdi  (i_tdi),
		.i_trst (i_trst),
		.o_tdo  (o_tdo),
		.dmi    (dmi)
	);

	debug_module u_dm (
		.clk        (clk),
		.i_rst      (rst_dmi),
		.dmi        (dmi),
		.hart       (hart_dbg),
		.o_ndmreset (ndmreset)
	);

	hart_regs u_hart (
		.clk   (clk),
		.i_rst (rst_hart),
		.dbg   (hart_dbg)
	);

	assign o_hart_halted = hart_dbg.halted;
	assign o_hart_running = hart_dbg.running;

endmodule

// ==== tests/debug_props.sv ====
// ------------------------------
// Checks scan results handed over by debug_tb
// Bound into debug_top, flags any failure in failed
// ------------------------------
module debug_props
	import debug_pkg::*;
	import jtag_pkg::*;
(
	input logic        clk,
	input logic        i_rst,
	input logic        i_rst_hart,
	input logic        i_halted,
	input logic        i_running,
	input logic        i_dmi_accept,
	input logic        i_dmi_rsp,
	input logic        i_acc_accept,
	input logic        i_acc_done,
	input logic        i_halt_req,
	input logic        i_chk_idcode,
	input logic        i_chk_dtmcs,
	input logic        i_chk_value,
	input logic        i_chk_failed,
	input logic        i_chk_success,
	input logic        i_chk_halted,
	input logic        i_chk_running,
	input logic        i_chk_cmderr,
	input logic [31:0] i_chk_data,
	input logic [1:0]  i_chk_stat,
	input logic [31:0] i_chk_exp
);

	timeunit 1ns;
	timeprecision 100ps;

	logic failed;

	initial failed = 1'b0;

	a_idcode: assert property (@(posedge clk) i_chk_idcode |-> i_chk_data == IDCODE_VALUE)
		else begin
			failed = 1'b1;
			$error("** Error t=%0t chk_data=%h expected %h", $time, $sampled(i_chk_data),
				IDCODE_VALUE);
		end

	// Version 1 in [3:0], abits 7 in [9:4]
	a_dtmcs: assert property (@(posedge clk) i_chk_dtmcs |-> i_chk_data[9:0] == {6'd7, 4'd1})
		else begin
			failed = 1'b1;
			$error("** Error t=%0t chk_data[9:0]=%h expected %h", $time,
				$sampled(i_chk_data[9:0]), {6'd7, 4'd1});
		end

	a_value: assert property (@(posedge clk)
		i_chk_value |-> i_chk_stat == 2'd0 && i_chk_data == i_chk_exp)
		else begin
			failed = 1'b1;
			$error("** Error t=%0t chk_stat=%0d expected 0, chk_data=%h expected %h", $time,
				$sampled(i_chk_stat), $sampled(i_chk_data), $sampled(i_chk_exp));
		end

	a_failed: assert property (@(posedge clk) i_chk_failed |-> i_chk_stat == 2'd2)
		else begin
			failed = 1'b1;
			$error("** Error t=%0t chk_stat=%0d expected 2", $time, $sampled(i_chk_stat));
		end

	a_success: assert property (@(posedge clk) i_chk_success |-> i_chk_stat == 2'd0)
		else begin
			failed = 1'b1;
			$error("** Error t=%0t chk_stat=%0d expected 0", $time, $sampled(i_chk_stat));
		end

	// allhalted and anyhalted
	a_halted: assert property (@(posedge clk)
		i_chk_halted |-> i_halted && i_chk_data[9:8] == 2'b11)
		else begin
			failed = 1'b1;
			$error("** Error t=%0t o_hart_halted=%b expected 1, chk_data[9:8]=%b expected 11",
				$time, $sampled(i_halted), $sampled(i_chk_data[9:8]));
		end

	// allrunning and allresumeack
	a_running: assert property (@(posedge clk)
		i_chk_running |-> i_running && i_chk_data[11] && i_chk_data[17])
		else begin
			failed = 1'b1;
			$error("** Error t=%0t o_hart_running=%b expected 1, chk_data=%h expected %h set",
				$time, $sampled(i_running), $sampled(i_chk_data), 32'h0002_0800);
		end

	// Busy clear and cmderr as expected
	a_cmderr: assert property (@(posedge clk)
		i_chk_cmderr |-> i_chk_stat == 2'd0 && i_chk_data[12:8] == {2'b00, i_chk_exp[2:0]})
		else begin
			failed = 1'b1;
			$error("** Error t=%0t chk_data[12:8]=%b expected %b, chk_stat=%0d", $time,
				$sampled(i_chk_data[12:8]), {2'b00, $sampled(i_chk_exp[2:0])},
				$sampled(i_chk_stat));
		end

	a_dmi_rsp: assert property (@(posedge clk) disable iff (i_rst) i_dmi_accept |=> i_dmi_rsp)
		else begin
			failed = 1'b1;
			$error("** Error t=%0t dmi.rsp_valid=%b expected 1", $time, $sampled(i_dmi_rsp));
		end

	a_acc_done: assert property (@(posedge clk)
		disable iff (i_rst_hart) i_acc_accept |=> i_acc_done)
		else begin
			failed = 1'b1;
			$error("** Error t=%0t acc_done=%b expected 1", $time, $sampled(i_acc_done));
		end

	a_halt_delay: assert property (@(posedge clk)
		disable iff (i_rst_hart) i_halt_req && !i_halted |=> i_halted)
		else begin
			failed = 1'b1;
			$error("** Error t=%0t o_hart_halted=%b expected 1", $time, $sampled(i_halted));
		end

endmodule

// ==== tests/debug_tb.sv ====
// ------------------------------
// Directed JTAG sequence, checks live in debug_props
// ------------------------------
module debug_tb
	import debug_pkg::*;
	import jtag_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int K_IDCODE = 1;
	localparam int K_DTMCS = 2;
	localparam int K_VALUE = 3;
	localparam int K_FAILED = 4;
	localparam int K_SUCCESS = 5;
	localparam int K_HALTED = 6;
	localparam int K_RUNNING = 7;
	localparam int K_CMDERR = 8;

	logic clk, i_rst, i_tck, i_tms, i_tdi, i_trst;
	logic o_tdo, o_hart_halted, o_hart_running;

	// Scan results handed to the bound checkers
	logic        chk_stb;
	int          chk_kind;
	logic [31:0] chk_data, chk_exp;
	logic [1:0]  chk_stat;
	logic        chk_idcode, chk_dtmcs, chk_value, chk_failed;
	logic        chk_success, chk_halted, chk_running, chk_cmderr;
	integer      seed;

	assign chk_idcode = chk_stb && chk_kind == K_IDCODE;
	assign chk_dtmcs = chk_stb && chk_kind == K_DTMCS;
	assign chk_value = chk_stb && chk_kind == K_VALUE;
	assign chk_failed = chk_stb && chk_kind == K_FAILED;
	assign chk_success = chk_stb && chk_kind == K_SUCCESS;
	assign chk_halted = chk_stb && chk_kind == K_HALTED;
	assign chk_running = chk_stb && chk_kind == K_RUNNING;
	assign chk_cmderr = chk_stb && chk_kind == K_CMDERR;

	debug_top dut (
		.clk            (clk),
		.i_rst          (i_rst),
		.i_tck          (i_tck),
		.i_tms          (i_tms),
		.i_tdi          (i_tdi),
		.i_trst         (i_trst),
		.o_tdo          (o_tdo),
		.o_hart_halted  (o_hart_halted),
		.o_hart_running (o_hart_running)
	);

	bind debug_top debug_props u_props (
		.clk           (clk),
		.i_rst         (rst_dmi),
		.i_rst_hart    (rst_hart),
		.i_halted      (o_hart_halted),
		.i_running     (o_hart_running),
		.i_dmi_accept  (dmi.req_valid & dmi.req_ready),
		.i_dmi_rsp     (dmi.rsp_valid),
		.i_acc_accept  (hart_dbg.acc_valid & hart_dbg.acc_ready),
		.i_acc_done    (hart_dbg.acc_done),
		.i_halt_req    (hart_dbg.halt_req),
		.i_chk_idcode  (debug_tb.chk_idcode),
		.i_chk_dtmcs   (debug_tb.chk_dtmcs),
		.i_chk_value   (debug_tb.chk_value),
		.i_chk_failed  (debug_tb.chk_failed),
		.i_chk_success (debug_tb.chk_success),
		.i_chk_halted  (debug_tb.chk_halted),
		.i_chk_running (debug_tb.chk_running),
		.i_chk_cmderr  (debug_tb.chk_cmderr),
		.i_chk_data    (debug_tb.chk_data),
		.i_chk_stat    (debug_tb.chk_stat),
		.i_chk_exp     (debug_tb.chk_exp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("tests failed");
		$fatal(1, "%s", why);
	endtask

	always @(negedge clk) begin
		if (dut.u_props.failed)
			abort_run("an assertion check failed");
	end

	// One TCK period, each level held for 6 clocks, TDO sampled before the rise
	task automatic tck_pulse(input logic tms_v, input logic tdi_v, output logic tdo_v);
		i_tms = tms_v;
		i_tdi = tdi_v;
		repeat (6) @(posedge clk);
		#1;
		tdo_v = o_tdo;
		i_tck = 1'b1;
		repeat (6) @(posedge clk);
		#1;
		i_tck = 1'b0;
	endtask

	task automatic tap_reset();
		logic unused;
		repeat (5) tck_pulse(1'b1, 1'b0, unused);
		tck_pulse(1'b0, 1'b0, unused);
	endtask

	task automatic scan_ir(input logic [4:0] code);
		logic unused;
		tck_pulse(1'b1, 1'b0, unused);
		tck_pulse(1'b1, 1'b0, unused);
		tck_pulse(1'b0, 1'b0, unused);
		tck_pulse(1'b0, 1'b0, unused);
		for (int i = 0; i < 5; i++)
			tck_pulse(i == 4, code[i], unused);
		tck_pulse(1'b1, 1'b0, unused);
		tck_pulse(1'b0, 1'b0, unused);
	endtask

	// Idle to Idle through Capture, Shift and Update
	task automatic scan_dr(input int len, input logic [40:0] din, output logic [40:0] dout);
		logic bit_out;
		dout = '0;
		tck_pulse(1'b1, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
		for (int i = 0; i < len; i++) begin
			tck_pulse(i == len - 1, din[i], bit_out);
			dout[i] = bit_out;
		end
		tck_pulse(1'b1, 1'b0, bit_out);
		tck_pulse(1'b0, 1'b0, bit_out);
	endtask

	// Request scan, then nop scans until the status is no longer busy
	task automatic dmi_access(input logic [6:0] addr, input logic [31:0] wdata,
		input dmi_op_t op, output logic [31:0] rdata, output logic [1:0] stat);
		logic [40:0] dout;
		int          tries;
		scan_dr(41, {addr, wdata, op}, dout);
		tries = 0;
		do begin
			scan_dr(41, {addr, 32'h0, DMI_OP_NOP}, dout);
			tries++;
		end while (dout[1:0] == DMI_OP_BUSY && tries < 8);
		if (dout[1:0] == DMI_OP_BUSY)
			abort_run("DMI status still busy after 8 status scans");
		rdata = dout[33:2];
		stat = dout[1:0];
	endtask

	task automatic dmi_write(input logic [6:0] addr, input logic [31:0] wdata,
		output logic [1:0] stat);
		logic [31:0] unused;
		dmi_access(addr, wdata, DMI_OP_WRITE, unused, stat);
	endtask

	task automatic dmi_read(input logic [6:0] addr, output logic [31:0] rdata,
		output logic [1:0] stat);
		dmi_access(addr, 32'h0, DMI_OP_READ, rdata, stat);
	endtask

	task automatic publish(input int kind, input logic [31:0] data, input logic [1:0] stat,
		input logic [31:0] exp);
		chk_kind = kind;
		chk_data = data;
		chk_stat = stat;
		chk_exp = exp;
		chk_stb = 1'b1;
		@(posedge clk);
		#1;
		chk_stb = 1'b0;
	endtask

	// At most 10 dmstatus reads, the last one is returned
	task automatic wait_dmstatus(input logic [31:0] mask, output logic [31:0] data);
		logic [1:0] stat;
		int         tries;
		tries = 0;
		do begin
			dmi_read(DM_DMSTATUS, data, stat);
			tries++;
		end while ((data & mask) != mask && tries < 10);
	endtask

	// At most 10 abstractcs reads, the last one is returned
	task automatic wait_abstract(output logic [31:0] data, output logic [1:0] stat);
		int tries;
		tries = 0;
		do begin
			dmi_read(DM_ABSTRACTCS, data, stat);
			tries++;
		end while (data[12] && tries < 10);
	endtask

	task automatic halt_hart();
		logic [31:0] data;
		logic [1:0]  stat;
		dmi_write(DM_DMCONTROL, 32'h8000_0001, stat);
		wait_dmstatus(32'h0000_0300, data);
		publish(K_HALTED, data, stat, 32'h0);
	endtask

	task automatic resume_hart();
		logic [31:0] data;
		logic [1:0]  stat;
		dmi_write(DM_DMCONTROL, 32'h4000_0001, stat);
		wait_dmstatus(32'h0002_0800, data);
		publish(K_RUNNING, data, stat, 32'h0);
	endtask

	task automatic run_command(input logic [31:0] cmd);
		logic [31:0] data;
		logic [1:0]  stat;
		dmi_write(DM_COMMAND, cmd, stat);
		wait_abstract(data, stat);
		publish(K_CMDERR, data, stat, 32'(CMDERR_NONE));
	endtask

	// Issue a failing command, check cmderr, then clear it with write-1
	task automatic expect_cmderr(input logic [31:0] cmd, input logic [2:0] err);
		logic [31:0] data;
		logic [1:0]  stat;
		dmi_write(DM_COMMAND, cmd, stat);
		wait_abstract(data, stat);
		publish(K_CMDERR, data, stat, 32'(err));
		dmi_write(DM_ABSTRACTCS, 32'h0000_0700, stat);
		wait_abstract(data, stat);
		publish(K_CMDERR, data, stat, 32'(CMDERR_NONE));
	endtask

	initial begin
		logic [31:0] rnd, data;
		logic [1:0]  stat;
		logic [40:0] dout;
		seed = 32'h8e2a7c12;
		i_rst = 1'b1;
		i_tck = 1'b0;
		i_tms = 1'b0;
		i_tdi = 1'b0;
		i_trst = 1'b0;
		chk_stb = 1'b0;
		chk_kind = 0;
		chk_data = '0;
		chk_stat = '0;
		chk_exp = '0;
		repeat (4) @(posedge clk);
		#1;
		i_rst = 1'b0;
		repeat (4) @(posedge clk);
		#1;

		// Test-Logic-Reset leaves IDCODE selected
		tap_reset();
		scan_dr(32, '0, dout);
		publish(K_IDCODE, dout[31:0], 2'd0, IDCODE_VALUE);
		scan_ir(IR_DTMCS);
		scan_dr(32, '0, dout);
		publish(K_DTMCS, dout[31:0], 2'd0, 32'h0);

		// data0 loopback, failed status and dmireset
		scan_ir(IR_DMI);
		rnd = $random(seed);
		dmi_write(DM_DATA0, rnd, stat);
		publish(K_SUCCESS, 32'h0, stat, 32'h0);
		dmi_read(DM_DATA0, data, stat);
		publish(K_VALUE, data, stat, rnd);
		dmi_read(7'h7f, data, stat);
		publish(K_FAILED, data, stat, 32'h0);
		scan_ir(IR_DTMCS);
		scan_dr(32, 41'h0_0001_0000, dout);
		scan_ir(IR_DMI);
		dmi_read(DM_DMSTATUS, data, stat);
		publish(K_SUCCESS, data, stat, 32'h0);

		// Run control
		dmi_write(DM_DMCONTROL, 32'h0000_0001, stat);
		halt_hart();
		resume_hart();

		// Write x5 from data0, then read it back and read x0
		halt_hart();
		rnd = $random(seed);
		dmi_write(DM_DATA0, rnd, stat);
		run_command(32'h0003_1005);
		dmi_write(DM_DATA0, ~rnd, stat);
		run_command(32'h0002_1005);
		dmi_read(DM_DATA0, data, stat);
		publish(K_VALUE, data, stat, rnd);
		run_command(32'h0002_1000);
		dmi_read(DM_DATA0, data, stat);
		publish(K_VALUE, data, stat, 32'h0);

		// Command errors
		resume_hart();
		expect_cmderr(32'h0002_1005, CMDERR_HALTRESUME);
		halt_hart();
		expect_cmderr(32'h0102_1005, CMDERR_NOTSUP);
		expect_cmderr(32'h0002_1010, CMDERR_EXCEPTION);

		// ndmreset clears the register file
		dmi_write(DM_DMCONTROL, 32'h0000_0003, stat);
		dmi_write(DM_DMCONTROL, 32'h0000_0001, stat);
		halt_hart();
		dmi_write(DM_DATA0, 32'hffff_ffff, stat);
		run_command(32'h0002_1005);
		dmi_read(DM_DATA0, data, stat);
		publish(K_VALUE, data, stat, 32'h0);

		repeat (2) @(posedge clk);
		#1;
		if (dut.u_props.failed) begin
			$display("tests failed");
			$fatal(1, "an assertion check failed");
		end else begin
			$display("all tests passed");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
source/debug_pkg.sv
source/jtag_pkg.sv
source/dmi_if.sv
source/hart_dbg_if.sv
source/reset_sync.sv
source/jtag_tap.sv
source/debug_module.sv
source/hart_regs.sv
source/debug_top.sv
tests/debug_props.sv
tests/debug_tb.sv
